//--- compile.f
+incdir+.
ddr_user_pkg.sv
ddr_mem_pkg.sv
wr_fifo_if.sv
wide_write_fifo.sv
ddr_write_ctrl.sv
ddr_write_top.sv
ddr_write_properties.sv
tb_ddr_write.sv

//--- ddr_mem_pkg.sv
`include "ddr_write_config.svh"

package ddr_mem_pkg;

    typedef logic [`DDR_BEAT_W-1:0] beat_t;       // eight words, word 0 in the low lane

    typedef logic [`DDR_BEAT_W/8-1:0] beat_strb_t;

    // number of beats is len + 1
    typedef logic [`DDR_BURST_W-1:0] burst_len_t;

    typedef enum logic [2:0] {
        IDLE,        // waiting for a client address
        WAIT,        // leading pads, then client words into the FIFO
        TRANS_ADDR,  // burst address on the memory side
        TRANS_DATA,  // slave pulls the burst beats
        AFTER        // trailing pads to complete the last beat
    } wr_state_e;

endpackage

//--- ddr_user_pkg.sv
`include "ddr_write_config.svh"

package ddr_user_pkg;

    // word address as seen by the client
    typedef logic [`DDR_ADDR_W-1:0] addr_t;

    // number of words is len + 1
    typedef logic [`DDR_LEN_W-1:0] len_t;

    // one enable per byte of a client word
    typedef logic [`DDR_USER_W/8-1:0] strb_t;

endpackage

//--- ddr_write_config.svh
`ifndef DDR_WRITE_CONFIG_SVH
`define DDR_WRITE_CONFIG_SVH

// client side
`define DDR_ADDR_W          28   // word address
`define DDR_USER_W          32   // client word
`define DDR_LEN_W           8    // words minus one

// memory side
`define DDR_BEAT_W          256
`define DDR_WORDS_PER_BEAT  8
`define DDR_BURST_W         4    // beats minus one
`define DDR_MAX_BURST       16

// packing FIFO, room for one burst filling while another drains
`define DDR_FIFO_BEATS      32
`define DDR_AFULL_BEATS     16   // complete beats that raise almost_full

`endif

//--- ddr_write_ctrl.sv
`timescale 1ns/10ps
`include "ddr_write_config.svh"

module ddr_write_ctrl (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     ddr_init_done,
    input  ddr_user_pkg::addr_t      wr_addr,
    input  ddr_user_pkg::len_t       wr_len,
    input  logic                     wr_addr_valid,
    output logic                     wr_addr_ready,
    input  logic [`DDR_USER_W-1:0]   wr_data,
    input  ddr_user_pkg::strb_t      wr_strb,
    input  logic                     wr_data_valid,
    input  logic                     wr_data_last,
    output logic                     wr_data_ready,
    output ddr_user_pkg::addr_t      write_addr,
    output ddr_mem_pkg::burst_len_t  write_len,
    output logic                     write_addr_valid,
    input  logic                     write_addr_ready,
    input  logic                     write_data_ready,
    input  logic                     write_data_last,
    wr_fifo_if.ctrl                  fifo
);

    localparam int OFF_W = $clog2(`DDR_WORDS_PER_BEAT);
    localparam int CNT_W = 9;   // beats of the longest padded transfer

    ddr_mem_pkg::wr_state_e cur_st;
    ddr_mem_pkg::wr_state_e nxt_st;

    ddr_user_pkg::addr_t end_addr;     // inclusive last word
    ddr_user_pkg::addr_t beat_span;
    ddr_user_pkg::addr_t addr_q;
    logic [CNT_W-1:0]    beats_left;
    logic [CNT_W-1:0]    burst_beats;
    logic [OFF_W-1:0]    lead_cnt;
    logic [OFF_W-1:0]    tail_cnt;
    logic                last_seen;
    logic                last_burst;
    logic                addr_valid_q;
    logic                addr_acc;
    logic                addr_hs;
    logic                data_acc;
    logic                lead_pad;
    logic                tail_pad;
    logic                pad_wr;
    logic                burst_done;

    assign end_addr  = wr_addr + ddr_user_pkg::addr_t'(wr_len);
    assign beat_span = (end_addr >> OFF_W) - (wr_addr >> OFF_W);

    assign addr_acc   = wr_addr_valid && wr_addr_ready;
    assign addr_hs    = write_addr_valid && write_addr_ready;
    assign data_acc   = wr_data_valid && wr_data_ready;
    assign lead_pad   = (cur_st == ddr_mem_pkg::WAIT) && (lead_cnt != '0);
    assign tail_pad   = (cur_st == ddr_mem_pkg::AFTER) && (tail_cnt != '0);
    assign pad_wr     = lead_pad || tail_pad;
    assign burst_done = (cur_st == ddr_mem_pkg::TRANS_DATA) && write_data_ready && write_data_last;

    assign wr_addr_ready = ddr_init_done && (cur_st == ddr_mem_pkg::IDLE);
    // client words are taken in any busy state except the trailing pads
    assign wr_data_ready = ddr_init_done && !last_seen && !fifo.full && (lead_cnt == '0)
                           && (cur_st inside {ddr_mem_pkg::WAIT, ddr_mem_pkg::TRANS_ADDR,
                                              ddr_mem_pkg::TRANS_DATA});

    assign fifo.wr_en   = (pad_wr && !fifo.full) || data_acc;
    assign fifo.wr_data = pad_wr ? '0 : wr_data;   // pads carry no byte enables
    assign fifo.wr_strb = pad_wr ? '0 : wr_strb;

    assign write_addr       = addr_q;
    assign write_addr_valid = ddr_init_done && addr_valid_q;
    assign write_len        = (beats_left >= CNT_W'(`DDR_MAX_BURST))
                              ? ddr_mem_pkg::burst_len_t'(`DDR_MAX_BURST - 1)
                              : ddr_mem_pkg::burst_len_t'(beats_left - 1'b1);
    assign burst_beats      = CNT_W'(write_len) + 1'b1;

    always_comb begin
        nxt_st = cur_st;
        case (cur_st)
            ddr_mem_pkg::IDLE: begin
                if (addr_acc) begin
                    nxt_st = ddr_mem_pkg::WAIT;
                end
            end
            ddr_mem_pkg::WAIT: begin
                if (lead_cnt == '0) begin
                    if (fifo.almost_full) begin
                        nxt_st = ddr_mem_pkg::TRANS_ADDR;   // a full burst is stored
                    end else if (last_seen) begin
                        nxt_st = ddr_mem_pkg::AFTER;
                    end
                end
            end
            ddr_mem_pkg::TRANS_ADDR: begin
                if (addr_hs) begin
                    nxt_st = ddr_mem_pkg::TRANS_DATA;
                end
            end
            ddr_mem_pkg::TRANS_DATA: begin
                if (burst_done) begin
                    nxt_st = last_burst ? ddr_mem_pkg::IDLE : ddr_mem_pkg::WAIT;
                end
            end
            ddr_mem_pkg::AFTER: begin
                if (tail_cnt == '0) begin
                    nxt_st = ddr_mem_pkg::TRANS_ADDR;
                end
            end
            default: nxt_st = ddr_mem_pkg::IDLE;
        endcase
    end

    // burst address only moves on acceptance and on each address handshake
    always_ff @(posedge clk) begin
        if (addr_acc) begin
            addr_q <= {wr_addr[`DDR_ADDR_W-1:OFF_W], OFF_W'(0)};   // aligned down
        end else if (addr_hs) begin
            addr_q <= addr_q + (ddr_user_pkg::addr_t'(burst_beats) << OFF_W);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            cur_st       <= ddr_mem_pkg::IDLE;
            beats_left   <= '0;
            lead_cnt     <= '0;
            tail_cnt     <= '0;
            last_seen    <= 1'b0;
            last_burst   <= 1'b0;
            addr_valid_q <= 1'b0;
        end else begin
            cur_st <= nxt_st;

            if (addr_acc) begin
                beats_left <= beat_span[CNT_W-1:0] + 1'b1;
                lead_cnt   <= wr_addr[OFF_W-1:0];
                tail_cnt   <= OFF_W'(`DDR_WORDS_PER_BEAT - 1) - end_addr[OFF_W-1:0];
            end else begin
                if (addr_hs) begin
                    beats_left <= beats_left - burst_beats;
                end
                if (lead_pad && !fifo.full) begin
                    lead_cnt <= lead_cnt - 1'b1;
                end
                if (tail_pad && !fifo.full) begin
                    tail_cnt <= tail_cnt - 1'b1;
                end
            end

            if (cur_st == ddr_mem_pkg::IDLE) begin
                last_seen <= 1'b0;
            end else if (data_acc && wr_data_last) begin
                last_seen <= 1'b1;
            end

            if (cur_st == ddr_mem_pkg::IDLE) begin
                last_burst <= 1'b0;
            end else if (addr_hs) begin
                last_burst <= beats_left <= CNT_W'(`DDR_MAX_BURST);   // nothing left after it
            end

            // valid follows the state by one cycle and drops on the handshake
            if (addr_hs) begin
                addr_valid_q <= 1'b0;
            end else if (cur_st == ddr_mem_pkg::TRANS_ADDR) begin
                addr_valid_q <= 1'b1;
            end
        end
    end

endmodule

//--- ddr_write_properties.sv
`timescale 1ns/10ps
`include "ddr_write_config.svh"

module ddr_write_properties (
    input logic                    clk,
    input logic                    rst,
    input logic                    ddr_init_done,
    input logic                    wr_addr_ready,
    input logic                    wr_data_ready,
    input logic [`DDR_ADDR_W-1:0]  write_addr,
    input logic [`DDR_BURST_W-1:0] write_len,
    input logic                    write_addr_valid,
    input logic                    write_addr_ready
);

    int fail_cnt = 0;

    valid_after_init: assert property (@(posedge clk) disable iff (rst)
        write_addr_valid |-> ddr_init_done)
    else begin
        $error("write_addr_valid high while ddr_init_done is low");
        fail_cnt++;
    end

    burst_in_range: assert property (@(posedge clk) disable iff (rst)
        write_addr_valid |-> (int'(write_len) + 1 <= `DDR_MAX_BURST))
    else begin
        $error("write_len 0x%0h above the burst limit", write_len);
        fail_cnt++;
    end

    addr_on_beat: assert property (@(posedge clk) disable iff (rst)
        write_addr_valid |-> (write_addr[2:0] == 3'd0))   // 8-word beats
    else begin
        $error("write_addr 0x%07h not beat aligned", write_addr);
        fail_cnt++;
    end

    one_ready_only: assert property (@(posedge clk) disable iff (rst)
        !(wr_data_ready && wr_addr_ready))
    else begin
        $error("wr_data_ready and wr_addr_ready high together");
        fail_cnt++;
    end

    addr_held: assert property (@(posedge clk) disable iff (rst)
        write_addr_valid && !write_addr_ready
        |=> write_addr_valid && $stable(write_addr) && $stable(write_len))
    else begin
        $error("burst address or length changed while stalled");
        fail_cnt++;
    end

endmodule

bind ddr_write_top ddr_write_properties u_props (
    .clk              (clk),
    .rst              (rst),
    .ddr_init_done    (ddr_init_done),
    .wr_addr_ready    (wr_addr_ready),
    .wr_data_ready    (wr_data_ready),
    .write_addr       (write_addr),
    .write_len        (write_len),
    .write_addr_valid (write_addr_valid),
    .write_addr_ready (write_addr_ready)
);

//--- ddr_write_top.sv
`timescale 1ns/10ps
`include "ddr_write_config.svh"

module ddr_write_top (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     ddr_init_done,

    input  logic [`DDR_ADDR_W-1:0]   wr_addr,
    input  logic [`DDR_LEN_W-1:0]    wr_len,
    input  logic                     wr_addr_valid,
    output logic                     wr_addr_ready,

    input  logic [`DDR_USER_W-1:0]   wr_data,
    input  logic [`DDR_USER_W/8-1:0] wr_strb,
    input  logic                     wr_data_valid,
    output logic                     wr_data_ready,
    input  logic                     wr_data_last,

    output logic [`DDR_ADDR_W-1:0]   write_addr,
    output logic [`DDR_BURST_W-1:0]  write_len,
    output logic                     write_addr_valid,
    input  logic                     write_addr_ready,

    output ddr_mem_pkg::beat_t       write_data,
    output ddr_mem_pkg::beat_strb_t  write_strb,
    input  logic                     write_data_ready,
    input  logic                     write_data_last
);

    wr_fifo_if fifo_bus ();

    ddr_write_ctrl u_ctrl (
        .clk              (clk),
        .rst              (rst),
        .ddr_init_done    (ddr_init_done),
        .wr_addr          (wr_addr),
        .wr_len           (wr_len),
        .wr_addr_valid    (wr_addr_valid),
        .wr_addr_ready    (wr_addr_ready),
        .wr_data          (wr_data),
        .wr_strb          (wr_strb),
        .wr_data_valid    (wr_data_valid),
        .wr_data_last     (wr_data_last),
        .wr_data_ready    (wr_data_ready),
        .write_addr       (write_addr),
        .write_len        (write_len),
        .write_addr_valid (write_addr_valid),
        .write_addr_ready (write_addr_ready),
        .write_data_ready (write_data_ready),
        .write_data_last  (write_data_last),
        .fifo             (fifo_bus.ctrl)
    );

    wide_write_fifo u_fifo (
        .clk      (clk),
        .rst      (rst),
        .wr       (fifo_bus.fifo),
        .rd_data  (write_data),
        .rd_strb  (write_strb),
        .rd_ready (write_data_ready),   // slave pulls one beat per ready cycle
        .empty    ()
    );

endmodule

//--- run_sim.sh
#!/bin/sh
# Verilator build and run of the DDR3 write bridge testbench

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/10ps \
    --top-module tb_ddr_write -Mdir obj_dir -f compile.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

# let assertion failures be counted instead of stopping at the first one
sim_out=$(./obj_dir/Vtb_ddr_write +verilator+error+limit+1000)
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx "Test OK"; then
    exit 0
fi
exit 1

//--- tb_ddr_write.sv
`timescale 1ns/10ps
`include "ddr_write_config.svh"

module tb_ddr_write;

    localparam int MEM_WORDS      = 1024;
    localparam int XFER_WAIT      = 4000;
    localparam int TIMEOUT_CYCLES = 20000;   // ~500 words in six tests, a few cycles each

    logic                    clk = 1'b0;
    logic                    rst = 1'b1;
    logic                    ddr_init_done = 1'b0;
    ddr_user_pkg::addr_t     wr_addr = '0;
    ddr_user_pkg::len_t      wr_len = '0;
    logic                    wr_addr_valid = 1'b0;
    logic                    wr_addr_ready;
    logic [`DDR_USER_W-1:0]  wr_data = '0;
    ddr_user_pkg::strb_t     wr_strb = '0;
    logic                    wr_data_valid = 1'b0;
    logic                    wr_data_ready;
    logic                    wr_data_last = 1'b0;
    ddr_user_pkg::addr_t     write_addr;
    ddr_mem_pkg::burst_len_t write_len;
    logic                    write_addr_valid;
    logic                    write_addr_ready = 1'b0;
    ddr_mem_pkg::beat_t      write_data;
    ddr_mem_pkg::beat_strb_t write_strb;
    logic                    write_data_ready = 1'b0;
    logic                    write_data_last = 1'b0;

    logic [31:0]         mem [MEM_WORDS];       // emulated DDR, one entry per word
    logic [31:0]         ref_mem [MEM_WORDS];
    integer              seed = 9927;
    int                  err_cnt = 0;
    int                  check_cnt = 0;
    int                  test_cnt = 0;
    int                  cycle_cnt = 0;
    bit                  stall_en = 1'b0;
    bit                  data_phase = 1'b0;
    ddr_user_pkg::addr_t exp_addr = '0;
    ddr_user_pkg::addr_t burst_base = '0;
    int                  exp_left = 0;       // beats of the transfer not yet addressed
    int                  burst_len = 0;
    int                  beat_idx = 0;
    int                  burst_cnt = 0;
    int                  beat_sum = 0;

    ddr_write_top u_ddr_write_top (
        .clk              (clk),
        .rst              (rst),
        .ddr_init_done    (ddr_init_done),
        .wr_addr          (wr_addr),
        .wr_len           (wr_len),
        .wr_addr_valid    (wr_addr_valid),
        .wr_addr_ready    (wr_addr_ready),
        .wr_data          (wr_data),
        .wr_strb          (wr_strb),
        .wr_data_valid    (wr_data_valid),
        .wr_data_ready    (wr_data_ready),
        .wr_data_last     (wr_data_last),
        .write_addr       (write_addr),
        .write_len        (write_len),
        .write_addr_valid (write_addr_valid),
        .write_addr_ready (write_addr_ready),
        .write_data       (write_data),
        .write_strb       (write_strb),
        .write_data_ready (write_data_ready),
        .write_data_last  (write_data_last)
    );

    initial begin
        forever #5 clk = ~clk;
    end

    // DDR slave, one burst at a time
    always @(posedge clk) begin : ddr_slave
        int w;
        int b;
        int idx;
        int exp_len;
        if (rst) begin
            write_addr_ready <= 1'b0;
            write_data_ready <= 1'b0;
            write_data_last  <= 1'b0;
            data_phase = 1'b0;
        end else begin
            if (data_phase && write_data_ready) begin
                for (w = 0; w < `DDR_WORDS_PER_BEAT; w++) begin
                    idx = int'(burst_base) + beat_idx * `DDR_WORDS_PER_BEAT + w;
                    for (b = 0; b < 4; b++) begin
                        if (write_strb[w*4+b]) begin
                            mem[idx][b*8 +: 8] = write_data[w*32+b*8 +: 8];
                        end
                    end
                end
                if (write_data_last) begin
                    data_phase = 1'b0;
                end
                beat_idx++;
            end
            if (write_addr_valid && write_addr_ready) begin
                exp_len = (exp_left > `DDR_MAX_BURST) ? `DDR_MAX_BURST - 1 : exp_left - 1;
                check_cnt++;
                assert (write_addr == exp_addr) else begin
                    $display("ERR write_addr 0x%07h, expected 0x%07h", write_addr, exp_addr);
                    err_cnt++;
                end
                check_cnt++;
                assert (int'(write_len) == exp_len) else begin
                    $display("ERR write_len 0x%0h, expected 0x%0h", write_len, exp_len);
                    err_cnt++;
                end
                burst_base = write_addr;
                burst_len  = int'(write_len);
                beat_idx   = 0;
                data_phase = 1'b1;
                burst_cnt++;
                beat_sum += burst_len + 1;
                exp_left -= exp_len + 1;
                exp_addr  = exp_addr + ddr_user_pkg::addr_t'((exp_len + 1) * 8);
            end
            write_addr_ready <= !stall_en || (($random(seed) & 3) != 0);
            write_data_ready <= data_phase && (!stall_en || (($random(seed) & 3) != 0));
            write_data_last  <= data_phase && (beat_idx == burst_len);
        end
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, a transfer never completed", cycle_cnt);
            $display("Test FAILED");
            $finish;
        end
    end

    function automatic int total_errors();
        return err_cnt + u_ddr_write_top.u_props.fail_cnt;
    endfunction

    task automatic finish_test(input string name, input int errs_before);
        test_cnt++;
        $display("test %0d %s: %s", test_cnt, name,
                 (total_errors() == errs_before) ? "pass" : "fail");
    endtask

    task automatic compare_mem();
        int a;
        for (a = 0; a < MEM_WORDS; a++) begin
            check_cnt++;
            assert (mem[a] === ref_mem[a]) else begin
                $display("ERR mem[0x%03h] 0x%08h, ref_mem 0x%08h", a, mem[a], ref_mem[a]);
                err_cnt++;
            end
        end
    endtask

    // one client transfer, then wait for the bridge to go idle
    task automatic run_transfer(input int start, input int nwords, input bit rand_strb,
                                input bit gaps);
        int i;
        int b;
        int waited;
        int exp_beats;
        bit vld;
        logic [31:0] word;
        ddr_user_pkg::strb_t strb;
        exp_beats = ((start % 8) + nwords + 7) / 8;   // lead pads plus words, whole beats
        exp_addr  = ddr_user_pkg::addr_t'(start - start % 8);
        exp_left  = exp_beats;
        burst_cnt = 0;
        beat_sum  = 0;
        wr_addr       <= ddr_user_pkg::addr_t'(start);
        wr_len        <= ddr_user_pkg::len_t'(nwords - 1);
        wr_addr_valid <= 1'b1;
        @(posedge clk);
        while (!wr_addr_ready) begin
            @(posedge clk);
        end
        wr_addr_valid <= 1'b0;
        i = 0;
        word = $random(seed);
        strb = rand_strb ? ddr_user_pkg::strb_t'($random(seed)) : 4'hf;
        while (i < nwords) begin
            vld = !gaps || (($random(seed) & 3) != 0);
            wr_data_valid <= vld;
            wr_data       <= word;
            wr_strb       <= strb;
            wr_data_last  <= (i == nwords - 1);
            @(posedge clk);
            if (vld && wr_data_ready) begin
                for (b = 0; b < 4; b++) begin
                    if (strb[b]) begin
                        ref_mem[start + i][b*8 +: 8] = word[b*8 +: 8];
                    end
                end
                i++;
                word = $random(seed);
                strb = rand_strb ? ddr_user_pkg::strb_t'($random(seed)) : 4'hf;
            end
        end
        wr_data_valid <= 1'b0;
        wr_data_last  <= 1'b0;
        waited = 0;
        while (!wr_addr_ready && waited < XFER_WAIT) begin
            @(posedge clk);
            waited++;
        end
        check_cnt++;
        assert (wr_addr_ready) else begin
            $display("wr_addr_ready did not come back after the transfer at word %0d", start);
            err_cnt++;
        end
        check_cnt++;
        assert (beat_sum == exp_beats) else begin
            $display("ERR beat_sum 0x%0h, expected 0x%0h", beat_sum, exp_beats);
            err_cnt++;
        end
    endtask

    initial begin : main
        int a;
        int errs;
        for (a = 0; a < MEM_WORDS; a++) begin
            mem[a]     = 32'hd00d_0000 ^ 32'(a);
            ref_mem[a] = mem[a];
        end
        repeat (10) @(posedge clk);
        rst <= 1'b0;

        errs = total_errors();
        wr_addr       <= ddr_user_pkg::addr_t'(8);
        wr_len        <= ddr_user_pkg::len_t'(7);
        wr_addr_valid <= 1'b1;   // offered while the controller is still calibrating
        repeat (20) begin
            @(posedge clk);
            check_cnt++;
            assert (!wr_addr_ready && !write_addr_valid) else begin
                $display("bridge answered before ddr_init_done was raised");
                err_cnt++;
            end
        end
        wr_addr_valid <= 1'b0;
        @(posedge clk);
        ddr_init_done <= 1'b1;
        finish_test("before init", errs);

        errs = total_errors();
        run_transfer(64, 16, 1'b0, 1'b0);
        check_cnt++;
        assert (burst_cnt == 1) else begin
            $display("ERR burst_cnt 0x%0h, expected 0x1", burst_cnt);
            err_cnt++;
        end
        compare_mem();
        finish_test("aligned write", errs);

        errs = total_errors();
        run_transfer(131, 18, 1'b1, 1'b0);   // offset 3, ends on word 4 of a beat
        compare_mem();
        finish_test("unaligned write", errs);

        errs = total_errors();
        run_transfer(261, 200, 1'b1, 1'b0);
        compare_mem();
        finish_test("long write", errs);

        errs = total_errors();
        stall_en = 1'b1;
        run_transfer(606, 150, 1'b1, 1'b1);
        compare_mem();
        finish_test("back-pressure", errs);

        errs = total_errors();
        run_transfer(801, 40, 1'b1, 1'b1);
        run_transfer(871, 33, 1'b1, 1'b1);
        compare_mem();
        finish_test("back-to-back", errs);

        $display("tests %0d, checks %0d, errors %0d, assertion failures %0d",
                 test_cnt, check_cnt, err_cnt, u_ddr_write_top.u_props.fail_cnt);
        if (total_errors() == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

//--- wide_write_fifo.sv
`timescale 1ns/10ps
`include "ddr_write_config.svh"

module wide_write_fifo (
    input  logic                    clk,
    input  logic                    rst,
    wr_fifo_if.fifo                 wr,
    output ddr_mem_pkg::beat_t      rd_data,
    output ddr_mem_pkg::beat_strb_t rd_strb,
    input  logic                    rd_ready,
    output logic                    empty
);

    localparam int PTR_W  = $clog2(`DDR_FIFO_BEATS);
    localparam int IDX_W  = $clog2(`DDR_WORDS_PER_BEAT);
    localparam int WSTB_W = `DDR_USER_W / 8;
    localparam int BSTB_W = `DDR_BEAT_W / 8;

    ddr_mem_pkg::beat_t      mem_data [`DDR_FIFO_BEATS];
    ddr_mem_pkg::beat_strb_t mem_strb [`DDR_FIFO_BEATS];

    ddr_mem_pkg::beat_t      pack_data;
    ddr_mem_pkg::beat_strb_t pack_strb;
    ddr_mem_pkg::beat_t      next_data;
    ddr_mem_pkg::beat_strb_t next_strb;
    logic [IDX_W-1:0]        word_idx;
    logic [PTR_W-1:0]        wr_ptr;
    logic [PTR_W-1:0]        rd_ptr;
    logic [PTR_W:0]          mem_cnt;    // beats stored behind the head register
    logic [PTR_W:0]          beat_cnt;
    logic                    head_valid;
    logic                    push;
    logic                    commit;
    logic                    consume;
    logic                    load;

    // new words shift in from the top, so word 0 ends in the low lane
    assign next_data = {wr.wr_data, pack_data[`DDR_BEAT_W-1:`DDR_USER_W]};
    assign next_strb = {wr.wr_strb, pack_strb[BSTB_W-1:WSTB_W]};

    assign push    = wr.wr_en && !wr.full;
    assign commit  = push && (word_idx == IDX_W'(`DDR_WORDS_PER_BEAT - 1));
    assign consume = rd_ready && head_valid;
    assign load    = (mem_cnt != '0) && (empty || consume);   // refill head

    assign empty          = !head_valid;
    assign beat_cnt       = mem_cnt + (PTR_W + 1)'(head_valid);
    assign wr.full        = beat_cnt >= (PTR_W + 1)'(`DDR_FIFO_BEATS);
    assign wr.almost_full = beat_cnt >= (PTR_W + 1)'(`DDR_AFULL_BEATS);

    always_ff @(posedge clk) begin
        if (push) begin
            pack_data <= next_data;
            pack_strb <= next_strb;
        end
        if (commit) begin
            mem_data[wr_ptr] <= next_data;
            mem_strb[wr_ptr] <= next_strb;
        end
        if (load) begin
            rd_data <= mem_data[rd_ptr];   // show-ahead head beat
            rd_strb <= mem_strb[rd_ptr];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            word_idx   <= '0;
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            mem_cnt    <= '0;
            head_valid <= 1'b0;
        end else begin
            if (push) begin
                word_idx <= word_idx + 1'b1;   // wraps after the eighth word
            end
            if (commit) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (load) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({commit, load})
                2'b10:   mem_cnt <= mem_cnt + 1'b1;
                2'b01:   mem_cnt <= mem_cnt - 1'b1;
                default: mem_cnt <= mem_cnt;
            endcase
            if (load) begin
                head_valid <= 1'b1;
            end else if (consume) begin
                head_valid <= 1'b0;
            end
        end
    end

endmodule

//--- wr_fifo_if.sv
`timescale 1ns/10ps
`include "ddr_write_config.svh"

interface wr_fifo_if;

    logic                        wr_en;
    logic [`DDR_USER_W-1:0]      wr_data;
    ddr_user_pkg::strb_t         wr_strb;
    logic                        full;
    logic                        almost_full;

    modport ctrl (
        output wr_en,
        output wr_data,
        output wr_strb,
        input  full,
        input  almost_full
    );

    modport fifo (
        input  wr_en,
        input  wr_data,
        input  wr_strb,
        output full,
        output almost_full
    );

endinterface
